//--- design/div_op_pkg.sv
// divide operation package
// one-hot operation codes and the consumer state encoding
`default_nettype none

package div_op_pkg;

  // one-hot op code, bit 7 is rem down to bit 0 divw
  typedef logic [7:0] div_op_t;

  // ========================================
  // operation codes
  localparam div_op_t OP_REM   = 8'b1000_0000;  // signed 64-bit remainder
  localparam div_op_t OP_REMU  = 8'b0100_0000;  // unsigned 64-bit remainder
  localparam div_op_t OP_REMUW = 8'b0010_0000;  // unsigned word remainder
  localparam div_op_t OP_REMW  = 8'b0001_0000;  // signed word remainder
  localparam div_op_t OP_DIV   = 8'b0000_1000;  // signed 64-bit quotient
  localparam div_op_t OP_DIVU  = 8'b0000_0100;  // unsigned 64-bit quotient
  localparam div_op_t OP_DIVUW = 8'b0000_0010;  // unsigned word quotient
  localparam div_op_t OP_DIVW  = 8'b0000_0001;  // signed word quotient

  // ========================================
  // consumer states
  typedef enum logic [1:0] {
    CORE_IDLE   = 2'd0,  // waiting for a request
    CORE_DIVIDE = 2'd1,  // one quotient bit per cycle
    CORE_DONE   = 2'd2   // result held until taken
  } core_state_t;

endpackage

`default_nettype wire

//--- design/div_data_pkg.sv
// divide data package
// operand widths and iteration counts of the restoring divider
`default_nettype none

package div_data_pkg;

  localparam int XLEN   = 64;  // fixed by the isa
  localparam int WORD_W = 32;

  // operand and result of a doubleword op
  typedef logic [XLEN-1:0] xlen_t;

  // low word operand of a w op
  typedef logic [WORD_W-1:0] word_t;

  // counts down the remaining quotient bits
  typedef logic [6:0] iter_cnt_t;

  // ========================================
  // iterations per operation size
  localparam iter_cnt_t ITER_DWORD = 7'd64;
  localparam iter_cnt_t ITER_WORD  = 7'd32;

endpackage

`default_nettype wire

//--- design/div_req_decode.sv
// divide request stage
// decodes the op, catches divide-by-zero and signed overflow,
// and registers operand magnitudes with the sign fix-up flags
`default_nettype none

module div_req_decode
  import div_op_pkg::*;
  import div_data_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  // request side
  input  wire          req_valid_i,
  output logic         req_ready_o,
  input  wire div_op_t req_op_i,
  input  wire xlen_t   req_dividend_i,
  input  wire xlen_t   req_divisor_i,
  // decoded side
  output logic         dec_valid_o,
  input  wire          dec_ready_i,
  output logic         dec_is_rem_o,
  output logic         dec_is_word_o,
  output xlen_t        dec_dividend_mag_o,
  output xlen_t        dec_divisor_mag_o,
  output logic         dec_q_neg_o,
  output logic         dec_r_neg_o,
  output logic         dec_exc_o,
  output xlen_t        dec_exc_result_o
);

  logic  is_rem;
  logic  is_word;
  logic  is_signed;
  word_t a_lo;
  word_t b_lo;
  xlen_t a_sext;     // dividend as a w op sees it
  xlen_t b_sext;
  xlen_t a_val;      // operand after word extension
  xlen_t b_val;
  logic  a_neg;
  logic  b_neg;
  logic  a_is_min;
  logic  div_zero;
  logic  div_ovf;
  xlen_t exc_result;
  xlen_t a_mag;
  xlen_t b_mag;
  logic  req_fire;

  // ========================================
  // op classification
  assign is_rem    = |(req_op_i & (OP_REM | OP_REMU | OP_REMW | OP_REMUW));
  assign is_word   = |(req_op_i & (OP_DIVW | OP_DIVUW | OP_REMW | OP_REMUW));
  assign is_signed = |(req_op_i & (OP_DIV | OP_DIVW | OP_REM | OP_REMW));

  assign a_lo   = req_dividend_i[31:0];
  assign b_lo   = req_divisor_i[31:0];
  assign a_sext = is_word ? {{32{a_lo[31]}}, a_lo} : req_dividend_i;
  assign b_sext = is_word ? {{32{b_lo[31]}}, b_lo} : req_divisor_i;

  // unsigned word ops see the low word zero extended
  assign a_val = (is_word && !is_signed) ? {32'b0, a_lo} : a_sext;
  assign b_val = (is_word && !is_signed) ? {32'b0, b_lo} : b_sext;

  assign a_neg = is_signed & a_val[63];
  assign b_neg = is_signed & b_val[63];

  // ========================================
  // exceptions
  assign a_is_min = is_word ? (a_lo == 32'h8000_0000) : (req_dividend_i == {1'b1, 63'b0});
  assign div_zero = (b_val == '0);
  assign div_ovf  = is_signed & a_is_min & (&b_val);  // most negative / -1

  always_comb begin
    if (div_zero) begin
      exc_result = is_rem ? a_sext : '1;
    end else if (div_ovf) begin
      exc_result = is_rem ? '0 : a_sext;
    end else begin
      exc_result = '0;
    end
  end

  // magnitudes, word ops end up with a clear upper half
  assign a_mag = a_neg ? (~a_val + 1'b1) : a_val;
  assign b_mag = b_neg ? (~b_val + 1'b1) : b_val;

  // ========================================
  // output slot
  assign req_ready_o = !dec_valid_o || dec_ready_i;  // empty or draining
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      dec_valid_o <= 1'b0;
    end else if (req_fire) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      dec_is_rem_o       <= is_rem;
      dec_is_word_o      <= is_word;
      dec_dividend_mag_o <= a_mag;
      dec_divisor_mag_o  <= b_mag;
      dec_q_neg_o        <= a_neg ^ b_neg;  // signs differ
      dec_r_neg_o        <= a_neg;          // remainder follows dividend
      dec_exc_o          <= div_zero | div_ovf;
      dec_exc_result_o   <= exc_result;
    end
  end

endmodule

`default_nettype wire

//--- design/div_req_fifo.sv
// divide request buffer
// in-order circular buffer for decoded requests, valid/ready both sides
`default_nettype none

module div_req_fifo
  import div_data_pkg::*;
#(
  parameter int FIFO_DEPTH = 4  // at least 2
) (
  input  wire        clk,
  input  wire        rst_n,
  // write side
  input  wire        wr_valid_i,
  output logic       wr_ready_o,
  input  wire        is_rem_i,
  input  wire        is_word_i,
  input  wire xlen_t dividend_mag_i,
  input  wire xlen_t divisor_mag_i,
  input  wire        q_neg_i,
  input  wire        r_neg_i,
  input  wire        exc_i,
  input  wire xlen_t exc_result_i,
  // read side
  output logic       rd_valid_o,
  input  wire        rd_ready_i,
  output logic       is_rem_o,
  output logic       is_word_o,
  output xlen_t      dividend_mag_o,
  output xlen_t      divisor_mag_o,
  output logic       q_neg_o,
  output logic       r_neg_o,
  output logic       exc_o,
  output xlen_t      exc_result_o
);

  localparam int PTR_W   = $clog2(FIFO_DEPTH);
  localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
  localparam int ENTRY_W = 5 + 3 * 64;  // five flags, three data words

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [ENTRY_W-1:0] wr_entry;
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               wr_fire;
  logic               rd_fire;

  assign wr_ready_o = (count != CNT_W'(FIFO_DEPTH));  // not full
  assign rd_valid_o = (count != '0);
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign rd_fire    = rd_valid_o && rd_ready_i;

  assign wr_entry = {is_rem_i, is_word_i, q_neg_i, r_neg_i, exc_i,
                     dividend_mag_i, divisor_mag_i, exc_result_i};

  // head entry straight out of the array
  assign {is_rem_o, is_word_o, q_neg_o, r_neg_o, exc_o,
          dividend_mag_o, divisor_mag_o, exc_result_o} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  // ========================================
  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/div_restore_core.sv
// restoring divider core
// one quotient bit per cycle on magnitudes, then sign fix, word sign
// extension and result select; exceptions bypass the iterations
`default_nettype none

module div_restore_core
  import div_op_pkg::*;
  import div_data_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  // request from the buffer
  input  wire        in_valid_i,
  output logic       in_ready_o,
  input  wire        is_rem_i,
  input  wire        is_word_i,
  input  wire xlen_t dividend_mag_i,
  input  wire xlen_t divisor_mag_i,
  input  wire        q_neg_i,
  input  wire        r_neg_i,
  input  wire        exc_i,
  input  wire xlen_t exc_result_i,
  // result
  output logic       res_valid_o,
  input  wire        res_ready_i,
  output xlen_t      res_data_o
);

  core_state_t  state;
  core_state_t  state_nxt;
  iter_cnt_t    cnt;
  logic         in_fire;

  // working registers of the current op
  logic [127:0] rq;         // remainder high, quotient low
  xlen_t        divisor;
  logic         is_rem_q;
  logic         is_word_q;
  logic         q_neg_q;
  logic         r_neg_q;
  logic         exc_q;

  logic [64:0]  diff;       // trial subtract, bit 64 is the borrow
  logic [127:0] rq_shift;
  xlen_t        quo;
  xlen_t        rem;
  xlen_t        quo_fix;
  xlen_t        rem_fix;
  xlen_t        pick;

  assign in_ready_o  = (state == CORE_IDLE);
  assign in_fire     = in_valid_i && in_ready_o;
  assign res_valid_o = (state == CORE_DONE);

  // ========================================
  // state machine
  always_comb begin
    state_nxt = state;
    case (state)
      CORE_IDLE: begin
        if (in_fire) begin
          state_nxt = exc_i ? CORE_DONE : CORE_DIVIDE;
        end
      end
      CORE_DIVIDE: begin
        if (cnt == iter_cnt_t'(1)) begin  // last bit this cycle
          state_nxt = CORE_DONE;
        end
      end
      CORE_DONE: begin
        if (res_ready_i) begin
          state_nxt = CORE_IDLE;
        end
      end
      default: state_nxt = CORE_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= CORE_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (in_fire) begin
        cnt <= is_word_i ? ITER_WORD : ITER_DWORD;
      end else if (state == CORE_DIVIDE) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // ========================================
  // datapath
  assign diff     = rq[127:63] - {1'b0, divisor};  // shifted remainder minus divisor
  assign rq_shift = {rq[126:0], 1'b0};

  always_ff @(posedge clk) begin
    if (in_fire) begin
      is_rem_q  <= is_rem_i;
      is_word_q <= is_word_i;
      q_neg_q   <= q_neg_i;
      r_neg_q   <= r_neg_i;
      exc_q     <= exc_i;
      divisor   <= divisor_mag_i;
      if (exc_i) begin
        rq <= {64'b0, exc_result_i};  // final value parked in the low half
      end else if (is_word_i) begin
        rq <= {64'b0, dividend_mag_i[31:0], 32'b0};  // word starts at bit 63
      end else begin
        rq <= {64'b0, dividend_mag_i};
      end
    end else if (state == CORE_DIVIDE) begin
      if (!diff[64]) begin
        rq <= {diff[63:0], rq_shift[63:1], 1'b1};  // fits, keep difference
      end else begin
        rq <= rq_shift;  // restore
      end
    end
  end

  // ========================================
  // sign fix and result select
  // word quotient lands zero extended in the low half
  assign quo     = rq[63:0];
  assign rem     = rq[127:64];
  assign quo_fix = q_neg_q ? (~quo + 1'b1) : quo;
  assign rem_fix = r_neg_q ? (~rem + 1'b1) : rem;
  assign pick    = is_rem_q ? rem_fix : quo_fix;

  always_comb begin
    if (exc_q) begin
      res_data_o = rq[63:0];  // already final, word forms extended
    end else if (is_word_q) begin
      res_data_o = {{32{pick[31]}}, pick[31:0]};
    end else begin
      res_data_o = pick;
    end
  end

endmodule

`default_nettype wire

//--- design/div_unit_top.sv
// integer divide unit
// request stage, request buffer and restoring divider in a chain;
// results return in request order
`default_nettype none

module div_unit_top
  import div_op_pkg::*;
  import div_data_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          req_valid_i,
  output logic         req_ready_o,
  input  wire div_op_t req_op_i,
  input  wire xlen_t   req_dividend_i,
  input  wire xlen_t   req_divisor_i,
  output logic         res_valid_o,
  input  wire          res_ready_i,
  output xlen_t        res_data_o
);

  // decode stage to buffer
  logic  dec_valid;
  logic  dec_ready;
  logic  dec_is_rem;
  logic  dec_is_word;
  xlen_t dec_dividend_mag;
  xlen_t dec_divisor_mag;
  logic  dec_q_neg;
  logic  dec_r_neg;
  logic  dec_exc;
  xlen_t dec_exc_result;

  // buffer to divider
  logic  fifo_valid;
  logic  fifo_ready;
  logic  fifo_is_rem;
  logic  fifo_is_word;
  xlen_t fifo_dividend_mag;
  xlen_t fifo_divisor_mag;
  logic  fifo_q_neg;
  logic  fifo_r_neg;
  logic  fifo_exc;
  xlen_t fifo_exc_result;

  div_req_decode u_decode (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_valid_i        (req_valid_i),
    .req_ready_o        (req_ready_o),
    .req_op_i           (req_op_i),
    .req_dividend_i     (req_dividend_i),
    .req_divisor_i      (req_divisor_i),
    .dec_valid_o        (dec_valid),
    .dec_ready_i        (dec_ready),
    .dec_is_rem_o       (dec_is_rem),
    .dec_is_word_o      (dec_is_word),
    .dec_dividend_mag_o (dec_dividend_mag),
    .dec_divisor_mag_o  (dec_divisor_mag),
    .dec_q_neg_o        (dec_q_neg),
    .dec_r_neg_o        (dec_r_neg),
    .dec_exc_o          (dec_exc),
    .dec_exc_result_o   (dec_exc_result)
  );

  div_req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_valid_i     (dec_valid),
    .wr_ready_o     (dec_ready),  // full stalls the decode slot
    .is_rem_i       (dec_is_rem),
    .is_word_i      (dec_is_word),
    .dividend_mag_i (dec_dividend_mag),
    .divisor_mag_i  (dec_divisor_mag),
    .q_neg_i        (dec_q_neg),
    .r_neg_i        (dec_r_neg),
    .exc_i          (dec_exc),
    .exc_result_i   (dec_exc_result),
    .rd_valid_o     (fifo_valid),
    .rd_ready_i     (fifo_ready),
    .is_rem_o       (fifo_is_rem),
    .is_word_o      (fifo_is_word),
    .dividend_mag_o (fifo_dividend_mag),
    .divisor_mag_o  (fifo_divisor_mag),
    .q_neg_o        (fifo_q_neg),
    .r_neg_o        (fifo_r_neg),
    .exc_o          (fifo_exc),
    .exc_result_o   (fifo_exc_result)
  );

  div_restore_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (fifo_valid),
    .in_ready_o     (fifo_ready),
    .is_rem_i       (fifo_is_rem),
    .is_word_i      (fifo_is_word),
    .dividend_mag_i (fifo_dividend_mag),
    .divisor_mag_i  (fifo_divisor_mag),
    .q_neg_i        (fifo_q_neg),
    .r_neg_i        (fifo_r_neg),
    .exc_i          (fifo_exc),
    .exc_result_i   (fifo_exc_result),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_data_o     (res_data_o)
  );

endmodule

`default_nettype wire

//--- tests/div_unit_asserts.sv
// divide unit protocol checks
// result handshake, reset behavior, buffer occupancy and divide length
`default_nettype none

module div_unit_asserts
  import div_op_pkg::*;
  import div_data_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input wire              clk,
  input wire              rst_n,
  input wire              res_valid_i,
  input wire              res_ready_i,
  input wire xlen_t       res_data_i,
  input wire              fifo_wr_fire_i,
  input wire              fifo_rd_fire_i,
  input wire core_state_t core_state_i
);

  localparam int USED_W = $clog2(FIFO_DEPTH + 1);

  logic [USED_W-1:0] fifo_used;      // buffer entries seen through its handshakes
  logic [7:0]        divide_cycles;  // cycles spent in the current divide

  always_ff @(posedge clk) begin
    if (rst_n) begin
      fifo_used <= '0;
    end else begin
      fifo_used <= fifo_used + USED_W'(fifo_wr_fire_i) - USED_W'(fifo_rd_fire_i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n || core_state_i != CORE_DIVIDE) begin
      divide_cycles <= '0;
    end else begin
      divide_cycles <= divide_cycles + 1'b1;
    end
  end

  // ========================================
  // result port
  result_held: assert property (@(posedge clk) disable iff (rst_n)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_data_i))
    else $error("result dropped or changed before its handshake");

  reset_quiet: assert property (@(posedge clk) rst_n |=> !res_valid_i)
    else $error("result valid during reset or right after it");

  // ========================================
  // buffer and divider
  no_write_full: assert property (@(posedge clk) disable iff (rst_n)
    !(fifo_wr_fire_i && fifo_used == USED_W'(FIFO_DEPTH)))
    else $error("request buffer written while full");

  no_read_empty: assert property (@(posedge clk) disable iff (rst_n)
    !(fifo_rd_fire_i && fifo_used == '0))
    else $error("request buffer read while empty");

  divide_bound: assert property (@(posedge clk) disable iff (rst_n)
    core_state_i == CORE_DIVIDE |-> divide_cycles < ITER_DWORD)
    else $error("divider stayed in the divide state too long");

endmodule

bind div_unit_top div_unit_asserts #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .res_valid_i    (res_valid_o),
  .res_ready_i    (res_ready_i),
  .res_data_i     (res_data_o),
  .fifo_wr_fire_i (u_fifo.wr_fire),
  .fifo_rd_fire_i (u_fifo.rd_fire),
  .core_state_i   (u_core.state)
);

`default_nettype wire

//--- tests/div_unit_tb.sv
// divide unit testbench
// random and corner divide requests against a reference model,
// results checked in order on each result handshake
`default_nettype none

module div_unit_tb
  import div_op_pkg::*;
  import div_data_pkg::*;
();

  localparam xlen_t MIN64     = {1'b1, 63'b0};
  localparam int    REQ_LIMIT = 300;  // cycles a request may stall

  logic    clk;
  logic    rst_n;
  logic    req_valid;
  logic    req_ready;
  div_op_t req_op;
  xlen_t   req_dividend;
  xlen_t   req_divisor;
  logic    res_valid;
  logic    res_ready;
  xlen_t   res_data;

  logic    toggle_ready;      // random backpressure on the result port
  xlen_t   exp_q [$];         // expected results in request order
  int      checks;
  int      errors;
  int      checks_at_start;
  int      errors_at_start;

  div_unit_top #(
    .FIFO_DEPTH (4)
  ) u_div_unit_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_op_i       (req_op),
    .req_dividend_i (req_dividend),
    .req_divisor_i  (req_divisor),
    .res_valid_o    (res_valid),
    .res_ready_i    (res_ready),
    .res_data_o     (res_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ========================================
  // reference model of the RISC-V M rules
  function automatic xlen_t sext32(input word_t v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic xlen_t expected_result(input div_op_t op, input xlen_t a, input xlen_t b);
    word_t aw;
    word_t bw;
    xlen_t r;
    aw = a[31:0];
    bw = b[31:0];
    r  = '0;
    case (op)
      OP_DIVU:  r = (b == '0) ? '1 : a / b;
      OP_REMU:  r = (b == '0) ? a : a % b;
      OP_DIVUW: r = sext32((bw == '0) ? '1 : aw / bw);
      OP_REMUW: r = sext32((bw == '0) ? aw : aw % bw);
      OP_DIV: begin
        if (b == '0)
          r = '1;
        else if (a == MIN64 && b == '1)
          r = a;  // overflow keeps the dividend
        else
          r = $signed(a) / $signed(b);
      end
      OP_REM: begin
        if (b == '0)
          r = a;
        else if (a == MIN64 && b == '1)
          r = '0;
        else
          r = $signed(a) % $signed(b);
      end
      OP_DIVW: begin
        if (bw == '0)
          r = '1;
        else if (aw == 32'h8000_0000 && bw == '1)
          r = sext32(aw);
        else
          r = sext32($signed(aw) / $signed(bw));
      end
      OP_REMW: begin
        if (bw == '0)
          r = sext32(aw);
        else if (aw == 32'h8000_0000 && bw == '1)
          r = '0;
        else
          r = sext32($signed(aw) % $signed(bw));
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic xlen_t rand64();
    return {$urandom, $urandom};
  endfunction

  // spread of divisor sizes so quotients vary in length
  function automatic xlen_t rand_divisor();
    xlen_t v;
    v = rand64() >> ($urandom % 64);
    if (v == '0)
      v = 64'd1;
    return v;
  endfunction

  // ========================================
  // checking and bookkeeping
  task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at time %0t: %s", $time, what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic start_test();
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name,
             checks - checks_at_start, errors - errors_at_start);
  endtask

  // sees pre-edge values since the DUT updates after the edge
  always @(posedge clk) begin : monitor
    xlen_t head;
    if (!rst_n && res_valid && res_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("result at time %0t arrived with no request outstanding", $time);
      end else begin
        head = exp_q.pop_front();
        check_value("res_data_o", res_data, head);
      end
    end
    if (!rst_n && req_valid && req_ready) begin
      exp_q.push_back(expected_result(req_op, req_dividend, req_divisor));
    end
  end

  always @(negedge clk) begin
    if (toggle_ready)
      res_ready = 1'($urandom_range(0, 1));
  end

  // ========================================
  // stimulus tasks start on a falling edge
  task automatic send_req(input div_op_t op, input xlen_t a, input xlen_t b);
    int waited;
    waited       = 0;
    req_valid    = 1'b1;
    req_op       = op;
    req_dividend = a;
    req_divisor  = b;
    @(posedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > REQ_LIMIT)
        report_timeout("request was never accepted");
      @(posedge clk);
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic drain(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > limit)
        report_timeout("results did not all come back");
    end
  endtask

  initial begin
    xlen_t   a;
    xlen_t   b;
    div_op_t op;
    div_op_t word_ops [4];
    rst_n        = 1'b1;  // active high
    req_valid    = 1'b0;
    req_op       = '0;
    req_dividend = '0;
    req_divisor  = '0;
    res_ready    = 1'b1;
    toggle_ready = 1'b0;
    checks       = 0;
    errors       = 0;
    word_ops     = '{OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    void'($urandom(32'hf74e));

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);

    start_test();
    check_value("res_valid_o", xlen_t'(res_valid), 64'd0);
    check_value("req_ready_o", xlen_t'(req_ready), 64'd1);
    end_test("reset");

    start_test();
    for (int i = 0; i < 12; i++) begin
      send_req(i[0] ? OP_REMU : OP_DIVU, rand64(), rand_divisor());
    end
    drain(2000);
    end_test("unsigned");

    start_test();
    for (int i = 0; i < 16; i++) begin
      a = rand64() >> 1;
      b = rand_divisor() >> 1;
      if (b == '0)
        b = 64'd3;
      if (i[0])
        a = -a;
      if (i[1])
        b = -b;
      send_req(i[2] ? OP_REM : OP_DIV, a, b);
    end
    drain(2000);
    end_test("signed");

    start_test();
    for (int i = 0; i < 16; i++) begin
      b = {$urandom, $urandom >> ($urandom % 32)};  // junk upper half
      if (b[31:0] == '0)
        b[0] = 1'b1;
      send_req(word_ops[i % 4], rand64(), b);
    end
    drain(2000);
    end_test("word");

    start_test();
    for (int i = 0; i < 8; i++) begin
      op = 8'b1 << i;
      b  = |(op & (OP_DIVW | OP_DIVUW | OP_REMW | OP_REMUW)) ? {$urandom, 32'h0} : '0;
      send_req(op, rand64(), b);
    end
    send_req(OP_DIV, MIN64, '1);
    send_req(OP_REM, MIN64, '1);
    send_req(OP_DIVW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff});
    send_req(OP_REMW, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff});
    drain(2000);
    end_test("exceptions");

    start_test();
    toggle_ready = 1'b1;
    for (int i = 0; i < 24; i++) begin
      op = 8'b1 << ($urandom % 8);
      send_req(op, rand64(), rand_divisor());
    end
    toggle_ready = 1'b0;
    res_ready    = 1'b1;
    drain(3000);
    end_test("back to back");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/div_op_pkg.sv
design/div_data_pkg.sv
design/div_req_decode.sv
design/div_req_fifo.sv
design/div_restore_core.sv
design/div_unit_top.sv
tests/div_unit_asserts.sv
tests/div_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = div_unit_tb
FILELIST  = src.f
LOG       = sim.log

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
